//--- Bender.yml
package:
  name: red_unit

export_include_dirs:
  - design

sources:
  - files:
      - design/red_pkg.sv
      - design/red_stage_if.sv
      - design/red_tree.sv
      - design/red_accum.sv
      - design/red_unit_top.sv
  - target: test
    files:
      - testbench/red_checker.sv
      - testbench/red_tb.sv

//--- design/red_accum.sv
`timescale 1ns/1ps
`default_nettype none

`include "red_macros.svh"

module red_accum (
    input  wire logic          clk,
    input  wire logic          rst_n,
    red_stage_if.consumer      in,
    output logic               result_valid_o,
    output red_pkg::red_elem_t result_o
);

    localparam int CNT_W = (`RED_BEATS > 1) ? $clog2(`RED_BEATS) : 1;

    // transfers seen so far in the current vector
    logic [CNT_W-1:0]   beat_cnt;
    logic               first_beat;
    logic               last_beat;

    // running fold of the current vector
    red_pkg::red_elem_t buff;
    red_pkg::red_elem_t folded;

    // opcode the vector started with
    red_pkg::red_op_e   vec_op;

    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == CNT_W'(`RED_BEATS - 1));

    // first partial passes through, later ones fold into the buffer
    assign folded = first_beat ? in.data : red_pkg::red_combine(in.op, buff, in.data);

    // --------------------
    // beat counter
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (in.valid) begin
            if (last_beat) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // --------------------
    // buffer and result
    // --------------------

    always_ff @(posedge clk) begin
        if (in.valid) begin
            buff <= folded;
            if (first_beat) begin
                vec_op <= in.op;
            end
            if (last_beat) begin
                result_o <= folded;
            end
        end
    end

    // single-cycle strobe with the result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= in.valid && last_beat;
        end
    end

    // all beats of one vector share the opcode of its first beat
    a_op_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (in.valid && !first_beat) |-> (in.op == vec_op)
    );

    // the strobe never stretches
    a_pulse_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid_o |=> !result_valid_o
    );

endmodule

`default_nettype wire

//--- design/red_macros.svh
`ifndef RED_MACROS_SVH
`define RED_MACROS_SVH

// --------------------
// vector geometry
// --------------------

// elements presented on one beat
`define RED_LANES 8

// bits per element
`define RED_ELEM_W 16

// beats that make up one full vector
`define RED_BEATS 2

// --------------------
// tree shape
// --------------------

// log2 of the lane count, one register per level
`define RED_TREE_DEPTH 3

`endif

//--- design/red_pkg.sv
`default_nettype none

`include "red_macros.svh"

package red_pkg;

    // --------------------
    // opcodes
    // --------------------

    // signed and unsigned sums give the same bits, so one code covers both
    typedef enum logic [1:0] {
        RED_SUM  = 2'd0,
        RED_UMAX = 2'd1,
        RED_SMAX = 2'd2
    } red_op_e;

    // one vector element
    typedef logic [`RED_ELEM_W-1:0] red_elem_t;

    // --------------------
    // pairwise combine
    // --------------------

    // shared by every tree node and the beat accumulator
    function automatic red_elem_t red_combine(
        input red_op_e   op,
        input red_elem_t a,
        input red_elem_t b
    );
        red_elem_t res;
        case (op)
            RED_SUM: begin
                // carry out is dropped, wraps modulo 2^W
                res = a + b;
            end
            RED_UMAX: begin
                res = (a > b) ? a : b;
            end
            RED_SMAX: begin
                res = ($signed(a) > $signed(b)) ? a : b;
            end
            default: begin
                res = a;
            end
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

//--- design/red_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// one partial result per cycle from the tree to the accumulator
interface red_stage_if;

    // partial present this cycle, consumer must take it
    logic               valid;
    // opcode that travelled with the beat
    red_pkg::red_op_e   op;
    // reduced value of one beat
    red_pkg::red_elem_t data;

    // tree side
    modport producer (
        output valid,
        output op,
        output data
    );

    // accumulator side
    modport consumer (
        input valid,
        input op,
        input data
    );

endinterface

`default_nettype wire

//--- design/red_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "red_macros.svh"

module red_tree (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic                                    beat_valid_i,
    input  red_pkg::red_op_e                             op_i,
    input  wire logic [`RED_LANES-1:0][`RED_ELEM_W-1:0] operands_i,
    red_stage_if.producer                                out
);

    localparam int NODE_CNT = 2 * `RED_LANES - 1;

    // heap of tree nodes
    // leaves first, then each level's outputs, root last
    red_pkg::red_elem_t node [NODE_CNT];

    // valid flag per registered level
    logic [`RED_TREE_DEPTH-1:0] vld_q;
    // enable seen at the input of each level
    logic [`RED_TREE_DEPTH-1:0] lvl_en;
    // opcode seen at the input of each level
    red_pkg::red_op_e           lvl_op [`RED_TREE_DEPTH];
    // opcode held beside each level's data
    red_pkg::red_op_e           op_q   [`RED_TREE_DEPTH];

    // --------------------
    // leaves
    // --------------------

    for (genvar i = 0; i < `RED_LANES; i++) begin : g_leaf
        assign node[i] = operands_i[i];
    end

    // --------------------
    // control pipeline
    // --------------------

    assign lvl_en = {vld_q[`RED_TREE_DEPTH-2:0], beat_valid_i};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= lvl_en;
        end
    end

    // --------------------
    // reduction levels
    // --------------------

    for (genvar k = 0; k < `RED_TREE_DEPTH; k++) begin : g_level
        localparam int IN_BASE  = 2 * `RED_LANES - ((2 * `RED_LANES) >> k);
        localparam int OUT_BASE = 2 * `RED_LANES - ((2 * `RED_LANES) >> (k + 1));
        localparam int OUT_CNT  = `RED_LANES >> (k + 1);

        // level 0 takes the opcode straight from the port
        if (k == 0) begin : g_op_in
            assign lvl_op[k] = op_i;
        end else begin : g_op_prev
            assign lvl_op[k] = op_q[k-1];
        end

        always_ff @(posedge clk) begin
            if (lvl_en[k]) begin
                op_q[k] <= lvl_op[k];
            end
        end

        // adjacent pairs fold into one node each
        for (genvar i = 0; i < OUT_CNT; i++) begin : g_node
            always_ff @(posedge clk) begin
                if (lvl_en[k]) begin
                    node[OUT_BASE+i] <= red_pkg::red_combine(lvl_op[k],
                                                             node[IN_BASE+2*i],
                                                             node[IN_BASE+2*i+1]);
                end
            end
        end
    end

    // --------------------
    // root to accumulator
    // --------------------

    assign out.valid = vld_q[`RED_TREE_DEPTH-1];
    assign out.op    = op_q[`RED_TREE_DEPTH-1];
    assign out.data  = node[NODE_CNT-1];

    // an accepted beat must carry a defined opcode
    a_op_defined: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_valid_i |-> (op_i inside {red_pkg::RED_SUM, red_pkg::RED_UMAX, red_pkg::RED_SMAX})
    );

endmodule

`default_nettype wire

//--- design/red_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "red_macros.svh"

module red_unit_top (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,

    // beat input
    input  wire logic                                    beat_valid_i,
    input  red_pkg::red_op_e                             op_i,
    input  wire logic [`RED_LANES-1:0][`RED_ELEM_W-1:0] operands_i,

    // per-vector result
    output logic                                         result_valid_o,
    output logic [`RED_ELEM_W-1:0]                       result_o
);

    // --------------------
    // tree to accumulator
    // --------------------

    red_stage_if stage_bus ();

    // folds one beat into one partial
    red_tree u_tree (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_valid_i (beat_valid_i),
        .op_i         (op_i),
        .operands_i   (operands_i),
        .out          (stage_bus.producer)
    );

    // merges partials over the beats of a vector
    red_accum u_accum (
        .clk            (clk),
        .rst_n          (rst_n),
        .in             (stage_bus.consumer),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/red_pkg.sv
design/red_stage_if.sv
design/red_tree.sv
design/red_accum.sv
design/red_unit_top.sv
testbench/red_checker.sv
testbench/red_tb.sv

//--- testbench/red_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "red_macros.svh"

module red_checker (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,

    // DUT ports being watched
    input  wire logic                                    beat_valid_i,
    input  wire red_pkg::red_op_e                        op_i,
    input  wire logic [`RED_LANES-1:0][`RED_ELEM_W-1:0] operands_i,
    input  wire logic                                    res_valid_i,
    input  wire logic [`RED_ELEM_W-1:0]                  res_i,

    // running tallies for the testbench
    output int                                           pass_cnt_o,
    output int                                           fail_cnt_o,
    output int                                           err_cnt_o,
    output int                                           pending_o
);

    localparam int VEC_LEN = `RED_LANES * `RED_BEATS;

    // elements of the vector being collected
    logic [`RED_ELEM_W-1:0] vec_elems [VEC_LEN];
    red_pkg::red_op_e       vec_op;
    int                     beat_idx = 0;
    int                     cyc = 0;
    int                     vec_no = 0;

    // one entry per outstanding vector, oldest first
    logic [`RED_ELEM_W-1:0] exp_q [$];
    int                     due_q [$];
    red_pkg::red_op_e       op_q [$];

    // values from the stimulus table, same order
    bit                     tbl_has_q [$];
    logic [`RED_ELEM_W-1:0] tbl_val_q [$];

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        err_cnt_o  = 0;
        pending_o  = 0;
    end

    // --------------------
    // reference model
    // --------------------

    // works on the whole vector at once, wide integers avoid overflow
    function automatic logic [`RED_ELEM_W-1:0] model_result(input red_pkg::red_op_e op);
        longint total;
        longint best;
        longint v;
        int     i;
        total = 0;
        best  = -(64'sd1 <<< 62);
        for (i = 0; i < VEC_LEN; i++) begin
            if (op == red_pkg::RED_SMAX) begin
                v = longint'($signed(vec_elems[i]));
            end else begin
                v = longint'(vec_elems[i]);
            end
            total = total + v;
            if (v > best) begin
                best = v;
            end
        end
        if (op == red_pkg::RED_SUM) begin
            return `RED_ELEM_W'(total);
        end
        return `RED_ELEM_W'(best);
    endfunction

    // called by the testbench when a row carries a hand-worked value
    task automatic note_table_value(input bit has_exp, input logic [`RED_ELEM_W-1:0] value);
        tbl_has_q.push_back(has_exp);
        tbl_val_q.push_back(value);
    endtask

    // --------------------
    // input side
    // --------------------

    task automatic take_beat();
        int l;
        for (l = 0; l < `RED_LANES; l++) begin
            vec_elems[beat_idx * `RED_LANES + l] = operands_i[l];
        end
        if (beat_idx == 0) begin
            vec_op = op_i;
        end
        if (beat_idx == `RED_BEATS - 1) begin
            exp_q.push_back(model_result(vec_op));
            due_q.push_back(cyc + `RED_TREE_DEPTH + 1);
            op_q.push_back(vec_op);
            beat_idx = 0;
        end else begin
            beat_idx = beat_idx + 1;
        end
    endtask

    // --------------------
    // output side
    // --------------------

    task automatic check_result();
        int                     due;
        logic [`RED_ELEM_W-1:0] exp;
        red_pkg::red_op_e       op;
        bit                     has_tbl;
        logic [`RED_ELEM_W-1:0] tbl;
        if (res_valid_i) begin
            if (due_q.size() == 0) begin
                $display("result_valid_o pulsed at cycle %0d with no vector outstanding", cyc);
                err_cnt_o++;
            end else begin
                due     = due_q.pop_front();
                exp     = exp_q.pop_front();
                op      = op_q.pop_front();
                has_tbl = tbl_has_q.pop_front();
                tbl     = tbl_val_q.pop_front();
                if (due != cyc) begin
                    $display("vector %0d result arrived at cycle %0d but was due at cycle %0d",
                             vec_no, cyc, due);
                    fail_cnt_o++;
                end else if (res_i !== exp) begin
                    $display("FAILED vector %0d result_o expected 0x%h got 0x%h",
                             vec_no, exp, res_i);
                    fail_cnt_o++;
                end else if (has_tbl && res_i !== tbl) begin
                    $display("FAILED vector %0d result_o table value 0x%h got 0x%h",
                             vec_no, tbl, res_i);
                    fail_cnt_o++;
                end else begin
                    $display("PASS vector %0d %s result_o 0x%h", vec_no, op.name(), res_i);
                    pass_cnt_o++;
                end
                vec_no++;
            end
        end else if (due_q.size() != 0 && due_q[0] < cyc) begin
            // pulse never came for the oldest vector
            $display("vector %0d result never arrived, it was due at cycle %0d",
                     vec_no, due_q[0]);
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
            void'(op_q.pop_front());
            void'(tbl_has_q.pop_front());
            void'(tbl_val_q.pop_front());
            fail_cnt_o++;
            vec_no++;
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!rst_n) begin
            beat_idx = 0;
        end else begin
            check_result();
            if (beat_valid_i) begin
                take_beat();
            end
        end
        pending_o = due_q.size();
    end

endmodule

`default_nettype wire

//--- testbench/red_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "red_macros.svh"

module red_tb;

    localparam int FIXED_ROWS = 7;
    localparam int RAND_ROWS  = 12;
    localparam int NUM_ROWS   = FIXED_ROWS + RAND_ROWS;
    localparam int VEC_LEN    = `RED_LANES * `RED_BEATS;
    localparam int MAX_GAP    = 3;
    localparam int CLK_PERIOD = 4;
    localparam int WDOG_CYC   = 2 * (NUM_ROWS * `RED_BEATS * (1 + MAX_GAP) + 20);

    logic                                    clk;
    logic                                    rst_n;
    logic                                    beat_valid_i;
    red_pkg::red_op_e                        op_i;
    logic [`RED_LANES-1:0][`RED_ELEM_W-1:0] operands_i;
    logic                                    result_valid_o;
    logic [`RED_ELEM_W-1:0]                  result_o;

    int pass_cnt;
    int fail_cnt;
    int err_cnt;
    int pending;
    int seed;

    // --------------------
    // stimulus table
    // --------------------

    red_pkg::red_op_e       row_op      [NUM_ROWS];
    logic [`RED_ELEM_W-1:0] row_elem    [NUM_ROWS][VEC_LEN];
    int                     row_gap     [NUM_ROWS];
    bit                     row_has_exp [NUM_ROWS];
    logic [`RED_ELEM_W-1:0] row_exp     [NUM_ROWS];

    // element i of the vector is base + i*step, wrapping
    task automatic set_fixed_row(input int idx, input red_pkg::red_op_e op,
                                 input logic [`RED_ELEM_W-1:0] base,
                                 input logic [`RED_ELEM_W-1:0] step,
                                 input int gap, input logic [`RED_ELEM_W-1:0] exp);
        int i;
        for (i = 0; i < VEC_LEN; i++) begin
            row_elem[idx][i] = base + step * i;
        end
        row_op[idx]      = op;
        row_gap[idx]     = gap;
        row_has_exp[idx] = 1'b1;
        row_exp[idx]     = exp;
    endtask

    task automatic fill_random_rows();
        int r;
        int i;
        for (r = FIXED_ROWS; r < NUM_ROWS; r++) begin
            // opcodes rotate so all three get random data
            row_op[r]      = red_pkg::red_op_e'((r - FIXED_ROWS) % 3);
            row_gap[r]     = $unsigned($random(seed)) % (MAX_GAP + 1);
            row_has_exp[r] = 1'b0;
            row_exp[r]     = '0;
            for (i = 0; i < VEC_LEN; i++) begin
                row_elem[r][i] = `RED_ELEM_W'($random(seed));
            end
        end
    endtask

    // --------------------
    // drivers
    // --------------------

    task automatic drive_beat(input int r, input int b);
        logic [`RED_LANES-1:0][`RED_ELEM_W-1:0] lanes;
        int l;
        for (l = 0; l < `RED_LANES; l++) begin
            lanes[l] = row_elem[r][b * `RED_LANES + l];
        end
        @(posedge clk);
        beat_valid_i <= 1'b1;
        op_i         <= row_op[r];
        operands_i   <= lanes;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        beat_valid_i <= 1'b0;
    endtask

    // --------------------
    // DUT and checker
    // --------------------

    red_unit_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .beat_valid_i   (beat_valid_i),
        .op_i           (op_i),
        .operands_i     (operands_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    red_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_valid_i (beat_valid_i),
        .op_i         (op_i),
        .operands_i   (operands_i),
        .res_valid_i  (result_valid_o),
        .res_i        (result_o),
        .pass_cnt_o   (pass_cnt),
        .fail_cnt_o   (fail_cnt),
        .err_cnt_o    (err_cnt),
        .pending_o    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bound derived from table length and worst gap
    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with results still outstanding", WDOG_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        beat_valid_i = 1'b0;
        op_i         = red_pkg::RED_SUM;
        operands_i   = '0;
        seed         = 32'hbf6b;

        // wrapping sum, then max rules on data with the top bit set
        set_fixed_row(0, red_pkg::RED_SUM,  16'hf000, 16'h0001, 0, 16'h0078);
        set_fixed_row(1, red_pkg::RED_UMAX, 16'h7ff8, 16'h0001, 0, 16'h8007);
        set_fixed_row(2, red_pkg::RED_SMAX, 16'h7ff8, 16'h0001, 0, 16'h7fff);
        // all negative
        set_fixed_row(3, red_pkg::RED_SMAX, 16'hffe1, 16'h0001, 0, 16'hfff0);
        set_fixed_row(4, red_pkg::RED_UMAX, 16'h0001, 16'h1111, 0, 16'heeef);
        // idle cycles between beats
        set_fixed_row(5, red_pkg::RED_SUM,  16'h1000, 16'h0100, 3, 16'h7800);
        set_fixed_row(6, red_pkg::RED_SMAX, 16'h8001, 16'h0f00, 2, 16'h6101);
        fill_random_rows();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // quiet stretch, no pulse expected here
        repeat (4) drive_idle();

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int b = 0; b < `RED_BEATS; b++) begin
                drive_beat(r, b);
                if (b == `RED_BEATS - 1) begin
                    chk.note_table_value(row_has_exp[r], row_exp[r]);
                end
                repeat (row_gap[r]) drive_idle();
            end
        end
        repeat (2) drive_idle();

        wait (pending == 0);
        repeat (`RED_TREE_DEPTH + 4) @(posedge clk);

        $display("vectors checked %0d, passed %0d, failed %0d, other errors %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && pass_cnt == NUM_ROWS) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
